/* flist.f */
+incdir+hdl
hdl/uart_line_pkg.sv
hdl/uart_status_pkg.sv
hdl/fifo_if.sv
hdl/baud_gen.sv
hdl/fifo_ctrl.sv
hdl/fifo.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_top.sv
verification/uart_tb.sv

/* hdl/baud_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module baud_gen
   (
   input  wire        clk,
   input  wire        reset,
   input  wire [10:0] dvsr,    // tick period minus one
   output logic       tick
   );

   logic [10:0] cnt_reg;
   logic        wrap;

   // >= so that a smaller divisor written mid-count takes effect at once
   assign wrap = (cnt_reg >= dvsr);

   always_ff @(posedge clk, posedge reset)
      if (reset)
         cnt_reg <= '0;
      else if (wrap)
         cnt_reg <= '0;
      else
         cnt_reg <= cnt_reg + 11'd1;

   assign tick = wrap;   // one clock per period

endmodule

`default_nettype wire

/* hdl/fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module fifo
   #(
   parameter int DATA_WIDTH = 8,
   parameter int ADDR_WIDTH = 4
   )
   (
   input wire  clk,
   input wire  reset,
   fifo_if.mem bus
   );

   logic [DATA_WIDTH-1:0] array_reg [2**ADDR_WIDTH];
   logic [ADDR_WIDTH-1:0] w_addr;
   logic [ADDR_WIDTH-1:0] r_addr;
   logic                  wr_en;

   // writes into a full queue are dropped
   assign wr_en = bus.wr & ~bus.full;

   always_ff @(posedge clk)
      if (wr_en)
         array_reg[w_addr] <= bus.w_data;

   // head word is always on the output
   assign bus.r_data = array_reg[r_addr];

   fifo_ctrl
      #(
      .ADDR_WIDTH (ADDR_WIDTH)
      )
   u_fifo_ctrl
      (
      .clk         (clk),
      .reset       (reset),
      .rd          (bus.rd),
      .wr          (bus.wr),
      .empty       (bus.empty),
      .full        (bus.full),
      .w_addr      (w_addr),
      .r_addr      (r_addr),
      .r_addr_next ()           // register file reads at r_addr directly
      );

endmodule

`default_nettype wire

/* hdl/fifo_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module fifo_ctrl
   #(
   parameter int ADDR_WIDTH = 4
   )
   (
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   rd,
   input  wire                   wr,
   output logic                  empty,
   output logic                  full,
   output logic [ADDR_WIDTH-1:0] w_addr,
   output logic [ADDR_WIDTH-1:0] r_addr,
   output logic [ADDR_WIDTH-1:0] r_addr_next  // for a synchronous read port
   );

   logic [ADDR_WIDTH-1:0] w_ptr_reg, w_ptr_next, w_ptr_succ;
   logic [ADDR_WIDTH-1:0] r_ptr_reg, r_ptr_next, r_ptr_succ;
   logic                  full_reg, full_next;
   logic                  empty_reg, empty_next;

   always_ff @(posedge clk, posedge reset)
      if (reset)
      begin
         w_ptr_reg <= '0;
         r_ptr_reg <= '0;
         full_reg  <= 1'b0;
         empty_reg <= 1'b1;
      end
      else
      begin
         w_ptr_reg <= w_ptr_next;
         r_ptr_reg <= r_ptr_next;
         full_reg  <= full_next;
         empty_reg <= empty_next;
      end

   assign w_ptr_succ = w_ptr_reg + 1'b1;
   assign r_ptr_succ = r_ptr_reg + 1'b1;

   always_comb
   begin
      w_ptr_next = w_ptr_reg;
      r_ptr_next = r_ptr_reg;
      full_next  = full_reg;
      empty_next = empty_reg;
      case ({wr, rd})
         2'b01:
            if (!empty_reg)
            begin
               r_ptr_next = r_ptr_succ;
               full_next  = 1'b0;
               if (r_ptr_succ == w_ptr_reg)
                  empty_next = 1'b1;   // last word gone
            end
         2'b10:
            if (!full_reg)
            begin
               w_ptr_next = w_ptr_succ;
               empty_next = 1'b0;
               if (w_ptr_succ == r_ptr_reg)
                  full_next = 1'b1;    // wrapped onto the reader
            end
         2'b11:
         begin
            // occupancy unchanged, both pointers step
            w_ptr_next = w_ptr_succ;
            r_ptr_next = r_ptr_succ;
         end
         default:
         begin
            w_ptr_next = w_ptr_reg;   // idle
         end
      endcase
   end

   assign w_addr      = w_ptr_reg;
   assign r_addr      = r_ptr_reg;
   assign r_addr_next = r_ptr_next;
   assign full        = full_reg;
   assign empty       = empty_reg;

endmodule

`default_nettype wire

/* hdl/fifo_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface fifo_if
   #(
   parameter int WIDTH = $bits(uart_status_pkg::rx_word_t)
   );

   logic             wr;
   logic             rd;
   logic [WIDTH-1:0] w_data;
   logic [WIDTH-1:0] r_data;   // head of queue, fall-through
   logic             empty;
   logic             full;

   // writer side
   modport producer (output wr, output w_data, input full);

   // reader side
   modport consumer (output rd, input r_data, input empty);

   // storage side, held by the fifo itself
   modport mem (input wr, input rd, input w_data, output r_data, output empty, output full);

endinterface

`default_nettype wire

/* hdl/uart_defs.svh */
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// widest data field in one frame
`define UART_DATA_W 8

// fifo address bits, depth is 2**AW
`define UART_FIFO_AW 4

// baud ticks per serial bit
`define UART_OVS 16

`endif

/* hdl/uart_line_pkg.sv */
`default_nettype none

package uart_line_pkg;

   typedef enum logic [1:0] {
      par_none = 2'b00,
      par_even = 2'b01,
      par_odd  = 2'b10
   } parity_t;

   // run-time frame format, shared by both directions
   typedef struct packed {
      logic    data_bits_7;  // set for 7 data bits
      logic    two_stop;
      parity_t parity;
   } frame_cfg_t;

endpackage

`default_nettype wire

/* hdl/uart_rx.sv */
`timescale 1ns/10ps
`default_nettype none

`include "uart_defs.svh"

module uart_rx
   (
   input  wire                       clk,
   input  wire                       reset,
   input  wire uart_line_pkg::frame_cfg_t cfg,
   input  wire                       tick,
   input  wire                       rx,
   input  wire                       clr_overrun,
   output logic                      overrun,
   fifo_if.producer                  fifo
   );

   import uart_line_pkg::*;
   import uart_status_pkg::*;

   localparam int SW = $clog2(`UART_OVS);
   localparam int NW = $clog2(`UART_DATA_W);

   typedef enum logic [2:0] {st_idle, st_start, st_data, st_parity, st_stop} state_t;

   state_t                  state_reg, state_next;
   logic [SW-1:0]           s_reg, s_next;     // ticks within a bit
   logic [NW-1:0]           n_reg, n_next;     // data or stop bit index
   logic [`UART_DATA_W-1:0] b_reg, b_next;
   logic                    par_reg, par_next;
   logic                    perr_reg, perr_next;
   logic                    ferr_reg, ferr_next;
   logic                    rx_meta, rx_s, rx_d;
   logic                    ovr_reg;
   logic                    push;
   logic                    mid_bit, end_bit;
   logic [NW-1:0]           last_bit;
   rx_word_t                word;

   // two-flop synchronizer plus one stage for edge detect
   always_ff @(posedge clk, posedge reset)
      if (reset)
      begin
         rx_meta <= 1'b1;
         rx_s    <= 1'b1;
         rx_d    <= 1'b1;
      end
      else
      begin
         rx_meta <= rx;
         rx_s    <= rx_meta;
         rx_d    <= rx_s;
      end

   always_ff @(posedge clk, posedge reset)
      if (reset)
      begin
         state_reg <= st_idle;
         s_reg     <= '0;
         n_reg     <= '0;
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
      end

   always_ff @(posedge clk)
   begin
      b_reg    <= b_next;
      par_reg  <= par_next;
      perr_reg <= perr_next;
      ferr_reg <= ferr_next;
   end

   assign mid_bit  = tick && (s_reg == SW'(`UART_OVS/2 - 1));
   assign end_bit  = tick && (s_reg == SW'(`UART_OVS - 1));
   assign last_bit = cfg.data_bits_7 ? NW'(`UART_DATA_W - 2) : NW'(`UART_DATA_W - 1);

   always_comb
   begin
      state_next = state_reg;
      s_next     = tick ? s_reg + 1'b1 : s_reg;
      n_next     = n_reg;
      b_next     = b_reg;
      par_next   = par_reg;
      perr_next  = perr_reg;
      ferr_next  = ferr_reg;
      push       = 1'b0;
      case (state_reg)
         st_idle:
         begin
            s_next = '0;
            if (rx_d && !rx_s)   // falling edge, start bit
               state_next = st_start;
         end
         st_start:
            if (mid_bit)
            begin
               s_next     = '0;
               n_next     = '0;
               par_next   = 1'b0;
               perr_next  = 1'b0;
               ferr_next  = 1'b0;
               state_next = rx_s ? st_idle : st_data;   // high again means glitch
            end
         st_data:
            if (end_bit)
            begin
               b_next   = {rx_s, b_reg[`UART_DATA_W-1:1]};   // lsb first
               par_next = par_reg ^ rx_s;
               n_next   = n_reg + 1'b1;
               if (n_reg == last_bit)
               begin
                  n_next     = '0;
                  state_next = (cfg.parity == par_none) ? st_stop : st_parity;
               end
            end
         st_parity:
            if (end_bit)
            begin
               perr_next  = par_reg ^ rx_s ^ (cfg.parity == par_odd);
               state_next = st_stop;
            end
         default:
            if (end_bit)
            begin
               ferr_next = ferr_reg | ~rx_s;
               if (cfg.two_stop && n_reg == '0)
                  n_next = NW'(1);
               else
               begin
                  push       = 1'b1;   // middle of the final stop bit
                  state_next = st_idle;
               end
            end
      endcase
   end

   // 7-bit frames leave the data one place too high
   assign word.data       = cfg.data_bits_7 ? {1'b0, b_reg[`UART_DATA_W-1:1]} : b_reg;
   assign word.parity_err = perr_reg;
   assign word.frame_err  = ferr_reg | ~rx_s;   // includes the sample taken now

   assign fifo.wr     = push & ~fifo.full;
   assign fifo.w_data = word;

   always_ff @(posedge clk, posedge reset)
      if (reset)
         ovr_reg <= 1'b0;
      else if (push && fifo.full)
         ovr_reg <= 1'b1;   // a new drop wins over clear
      else if (clr_overrun)
         ovr_reg <= 1'b0;

   assign overrun = ovr_reg;

endmodule

`default_nettype wire

/* hdl/uart_status_pkg.sv */
`default_nettype none

`include "uart_defs.svh"

package uart_status_pkg;

   // one entry of the receive fifo
   typedef struct packed {
      logic [`UART_DATA_W-1:0] data;   // 7-bit frames have msb cleared
      logic                    parity_err;
      logic                    frame_err;  // a stop sample read 0
   } rx_word_t;

endpackage

`default_nettype wire

/* hdl/uart_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "uart_defs.svh"

module uart_top
   (
   input  wire        clk,
   input  wire        reset,
   input  wire [10:0] dvsr,
   input  wire        data_bits_7,
   input  wire        two_stop,
   input  wire [1:0]  parity,
   input  wire        rx,
   input  wire        wr_uart,
   input  wire [7:0]  w_data,
   input  wire        rd_uart,
   input  wire        clr_overrun,
   output logic       tx,
   output logic       tx_full,
   output logic       rx_empty,
   output logic [7:0] r_data,
   output logic       parity_err,
   output logic       frame_err,
   output logic       overrun
   );

   import uart_line_pkg::*;
   import uart_status_pkg::*;

   frame_cfg_t cfg;
   rx_word_t   rx_head;
   logic       tick;

   fifo_if #(.WIDTH(`UART_DATA_W))     tx_fifo_bus ();
   fifo_if #(.WIDTH($bits(rx_word_t))) rx_fifo_bus ();

   assign cfg = '{data_bits_7: data_bits_7, two_stop: two_stop, parity: parity_t'(parity)};

   // user write side of the transmit queue
   assign tx_fifo_bus.wr     = wr_uart;
   assign tx_fifo_bus.w_data = w_data;
   assign tx_full            = tx_fifo_bus.full;

   // user read side of the receive queue
   assign rx_fifo_bus.rd = rd_uart;
   assign rx_empty       = rx_fifo_bus.empty;
   assign rx_head        = rx_fifo_bus.r_data;
   assign r_data         = rx_head.data;
   assign parity_err     = rx_head.parity_err;
   assign frame_err      = rx_head.frame_err;

   baud_gen u_baud_gen (.clk(clk), .reset(reset), .dvsr(dvsr), .tick(tick));

   uart_rx u_uart_rx
      (
      .clk         (clk),
      .reset       (reset),
      .cfg         (cfg),
      .tick        (tick),
      .rx          (rx),
      .clr_overrun (clr_overrun),
      .overrun     (overrun),
      .fifo        (rx_fifo_bus.producer)
      );

   uart_tx u_uart_tx
      (
      .clk   (clk),
      .reset (reset),
      .cfg   (cfg),
      .tick  (tick),
      .tx    (tx),
      .fifo  (tx_fifo_bus.consumer)
      );

   fifo #(.DATA_WIDTH(`UART_DATA_W), .ADDR_WIDTH(`UART_FIFO_AW)) u_tx_fifo
      (
      .clk   (clk),
      .reset (reset),
      .bus   (tx_fifo_bus.mem)
      );

   fifo #(.DATA_WIDTH($bits(rx_word_t)), .ADDR_WIDTH(`UART_FIFO_AW)) u_rx_fifo
      (
      .clk   (clk),
      .reset (reset),
      .bus   (rx_fifo_bus.mem)
      );

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

`include "uart_defs.svh"

module uart_tx
   (
   input  wire                       clk,
   input  wire                       reset,
   input  wire uart_line_pkg::frame_cfg_t cfg,
   input  wire                       tick,
   output logic                      tx,
   fifo_if.consumer                  fifo
   );

   import uart_line_pkg::*;

   localparam int SW = $clog2(`UART_OVS);
   localparam int NW = $clog2(`UART_DATA_W);

   typedef enum logic [2:0] {st_idle, st_start, st_data, st_parity, st_stop} state_t;

   state_t                  state_reg, state_next;
   logic [SW-1:0]           s_reg, s_next;
   logic [NW-1:0]           n_reg, n_next;
   logic [`UART_DATA_W-1:0] b_reg, b_next;
   logic                    par_reg, par_next;
   logic                    loaded_reg, loaded_next;   // byte waiting for a tick
   logic                    tx_reg, tx_next;
   logic                    end_bit;
   logic [`UART_DATA_W-1:0] mask;
   logic [NW-1:0]           last_bit;

   always_ff @(posedge clk, posedge reset)
      if (reset)
      begin
         state_reg  <= st_idle;
         s_reg      <= '0;
         n_reg      <= '0;
         loaded_reg <= 1'b0;
         tx_reg     <= 1'b1;   // line idles high
      end
      else
      begin
         state_reg  <= state_next;
         s_reg      <= s_next;
         n_reg      <= n_next;
         loaded_reg <= loaded_next;
         tx_reg     <= tx_next;
      end

   always_ff @(posedge clk)
   begin
      b_reg   <= b_next;
      par_reg <= par_next;
   end

   assign end_bit  = tick && (s_reg == SW'(`UART_OVS - 1));
   assign mask     = cfg.data_bits_7 ? {1'b0, {(`UART_DATA_W-1){1'b1}}} : '1;
   assign last_bit = cfg.data_bits_7 ? NW'(`UART_DATA_W - 2) : NW'(`UART_DATA_W - 1);

   always_comb
   begin
      state_next  = state_reg;
      s_next      = tick ? s_reg + 1'b1 : s_reg;
      n_next      = n_reg;
      b_next      = b_reg;
      par_next    = par_reg;
      loaded_next = loaded_reg;
      tx_next     = tx_reg;
      fifo.rd     = 1'b0;
      case (state_reg)
         st_idle:
         begin
            s_next = '0;
            if (loaded_reg)
            begin
               if (tick)
               begin
                  loaded_next = 1'b0;
                  tx_next     = 1'b0;   // start bit begins on this tick
                  state_next  = st_start;
               end
            end
            else if (!fifo.empty)
            begin
               fifo.rd     = 1'b1;
               b_next      = fifo.r_data;
               par_next    = ^(fifo.r_data & mask) ^ (cfg.parity == par_odd);
               loaded_next = 1'b1;
            end
         end
         st_start:
            if (end_bit)
            begin
               tx_next    = b_reg[0];
               n_next     = '0;
               state_next = st_data;
            end
         st_data:
            if (end_bit)
            begin
               if (n_reg == last_bit)
               begin
                  n_next = '0;
                  if (cfg.parity != par_none)
                  begin
                     tx_next    = par_reg;
                     state_next = st_parity;
                  end
                  else
                  begin
                     tx_next    = 1'b1;
                     state_next = st_stop;
                  end
               end
               else
               begin
                  b_next  = b_reg >> 1;
                  tx_next = b_reg[1];
                  n_next  = n_reg + 1'b1;
               end
            end
         st_parity:
            if (end_bit)
            begin
               tx_next    = 1'b1;
               state_next = st_stop;
            end
         default:
            if (end_bit)
            begin
               if (cfg.two_stop && n_reg == '0)
                  n_next = NW'(1);   // second stop bit
               else
                  state_next = st_idle;
            end
      endcase
   end

   assign tx = tx_reg;

endmodule

`default_nettype wire

/* verification/uart_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tb;

   import uart_line_pkg::*;

   localparam int DVSR         = 3;
   localparam int BIT_CLKS     = (DVSR + 1) * 16;   // 16 ticks per bit
   localparam int FRAME_CLKS   = 12 * BIT_CLKS;     // longest frame, 8 data + parity + 2 stop
   localparam int TOTAL_FRAMES = 10 + 12 + 2 + 17 + 17;
   localparam int TIMEOUT_CYC  = 2 * TOTAL_FRAMES * FRAME_CLKS;
   localparam int WAIT_LIMIT   = 2 * FRAME_CLKS;

   logic        clk;
   logic        reset;
   logic [10:0] dvsr;
   logic        data_bits_7;
   logic        two_stop;
   logic [1:0]  parity;
   logic        rx_line;
   logic        drv_rx;
   logic        loop_en;   // 1 routes tx back into rx
   logic        wr_uart;
   logic [7:0]  w_data;
   logic        rd_uart;
   logic        clr_overrun;
   logic        tx;
   logic        tx_full;
   logic        rx_empty;
   logic [7:0]  r_data;
   logic        parity_err;
   logic        frame_err;
   logic        overrun;

   int          err_cnt;
   int          check_cnt;
   int          cycle_cnt;
   logic [31:0] rng_state;
   logic [7:0]  sent_q[$];
   logic        full_seen;

   assign rx_line = loop_en ? tx : drv_rx;

   uart_top u_uart_top
      (
      .clk         (clk),
      .reset       (reset),
      .dvsr        (dvsr),
      .data_bits_7 (data_bits_7),
      .two_stop    (two_stop),
      .parity      (parity),
      .rx          (rx_line),
      .wr_uart     (wr_uart),
      .w_data      (w_data),
      .rd_uart     (rd_uart),
      .clr_overrun (clr_overrun),
      .tx          (tx),
      .tx_full     (tx_full),
      .rx_empty    (rx_empty),
      .r_data      (r_data),
      .parity_err  (parity_err),
      .frame_err   (frame_err),
      .overrun     (overrun)
      );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // run limit in clock cycles
   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYC)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout after %0d cycles, tests did not finish", cycle_cnt);
      $display("** FAIL **");
      $finish;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic next_byte(output logic [7:0] b);
      rng_state = xorshift32(rng_state);
      b         = rng_state[7:0];
   endtask

   task automatic compare_val(input string name, input logic [7:0] got, input logic [7:0] exp);
      check_cnt++;
      assert (got === exp)
      else
      begin
         err_cnt++;
         $display("error %s: expected %h, got %h", name, exp, got);
      end
   endtask

   task automatic expect_true(input logic cond, input string what);
      check_cnt++;
      assert (cond === 1'b1)
      else
      begin
         err_cnt++;
         $display("%s", what);
      end
   endtask

   task automatic set_format(input logic b7, input logic s2, input parity_t p);
      @(negedge clk);
      data_bits_7 = b7;
      two_stop    = s2;
      parity      = p;
   endtask

   task automatic hold_idle();
      repeat (2 * BIT_CLKS) @(negedge clk);   // lets the line finish its last stop bit
   endtask

   // back-to-back writes of the first n queued bytes
   task automatic write_bytes(input int n);
      int i;
      full_seen = 1'b0;
      for (i = 0; i < n; i++)
      begin
         @(negedge clk);
         full_seen = full_seen | tx_full;
         wr_uart   = 1'b1;
         w_data    = sent_q[i];
      end
      @(negedge clk);
      full_seen = full_seen | tx_full;
      wr_uart   = 1'b0;
   endtask

   task automatic await_rx_word();
      int n;
      n = 0;
      @(negedge clk);
      while (rx_empty && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      expect_true(!rx_empty, "no word reached the receive fifo in time");
   endtask

   task automatic read_word(input logic [7:0] exp_data, input logic exp_perr, input logic exp_ferr);
      await_rx_word();
      if (!rx_empty)
      begin
         compare_val("r_data", r_data, exp_data);
         compare_val("parity_err", parity_err, exp_perr);
         compare_val("frame_err", frame_err, exp_ferr);
         rd_uart = 1'b1;
         @(negedge clk);
         rd_uart = 1'b0;
      end
   endtask

   // drives one frame on drv_rx in the current format
   task automatic send_frame(input logic [7:0] data, input logic bad_par, input logic bad_stop);
      int   i;
      int   nbits;
      logic par;
      nbits = data_bits_7 ? 7 : 8;
      par   = ^(data & (data_bits_7 ? 8'h7f : 8'hff)) ^ (parity == par_odd) ^ bad_par;
      @(negedge clk);
      drv_rx = 1'b0;
      repeat (BIT_CLKS) @(negedge clk);
      for (i = 0; i < nbits; i++)
      begin
         drv_rx = data[i];
         repeat (BIT_CLKS) @(negedge clk);
      end
      if (parity != par_none)
      begin
         drv_rx = par;
         repeat (BIT_CLKS) @(negedge clk);
      end
      drv_rx = 1'b1;
      if (two_stop)
         repeat (BIT_CLKS) @(negedge clk);
      drv_rx = ~bad_stop;   // last stop bit
      repeat (BIT_CLKS) @(negedge clk);
      drv_rx = 1'b1;
   endtask

   task automatic reset_values();
      @(negedge clk);
      compare_val("tx", tx, 1'b1);
      compare_val("rx_empty", rx_empty, 1'b1);
      compare_val("tx_full", tx_full, 1'b0);
      compare_val("overrun", overrun, 1'b0);
   endtask

   task automatic loopback_8n1();
      logic [7:0] b;
      int         i;
      loop_en = 1'b1;
      set_format(1'b0, 1'b0, par_none);
      sent_q.delete();
      for (i = 0; i < 10; i++)
      begin
         next_byte(b);
         sent_q.push_back(b);
      end
      write_bytes(10);
      for (i = 0; i < 10; i++)
         read_word(sent_q[i], 1'b0, 1'b0);
      hold_idle();
   endtask

   task automatic loopback_formats();
      logic [7:0] b;
      int         i;
      set_format(1'b1, 1'b1, par_even);
      sent_q.delete();
      for (i = 0; i < 6; i++)
      begin
         next_byte(b);
         sent_q.push_back(b);
      end
      write_bytes(6);
      for (i = 0; i < 6; i++)
         read_word(sent_q[i] & 8'h7f, 1'b0, 1'b0);   // msb is not sent
      hold_idle();
      set_format(1'b0, 1'b0, par_odd);
      for (i = 0; i < 6; i++)
      begin
         next_byte(b);
         sent_q[i] = b;
      end
      write_bytes(6);
      for (i = 0; i < 6; i++)
         read_word(sent_q[i], 1'b0, 1'b0);
      hold_idle();
   endtask

   task automatic line_errors();
      loop_en = 1'b0;
      set_format(1'b0, 1'b0, par_even);
      send_frame(8'h5a, 1'b1, 1'b0);
      send_frame(8'h3c, 1'b0, 1'b1);
      read_word(8'h5a, 1'b1, 1'b0);
      read_word(8'h3c, 1'b0, 1'b1);
      hold_idle();
   endtask

   task automatic rx_overrun();
      logic [7:0] b;
      int         i;
      set_format(1'b0, 1'b0, par_none);
      sent_q.delete();
      for (i = 0; i < 17; i++)
      begin
         next_byte(b);
         sent_q.push_back(b);
         send_frame(b, 1'b0, 1'b0);
         if (i == 15)
            compare_val("overrun", overrun, 1'b0);   // fifo just filled
      end
      compare_val("overrun", overrun, 1'b1);
      for (i = 0; i < 16; i++)
         read_word(sent_q[i], 1'b0, 1'b0);
      compare_val("rx_empty", rx_empty, 1'b1);
      compare_val("overrun", overrun, 1'b1);
      clr_overrun = 1'b1;
      @(negedge clk);
      clr_overrun = 1'b0;
      compare_val("overrun", overrun, 1'b0);
   endtask

   task automatic tx_fifo_full();
      logic [7:0] b;
      int         i;
      loop_en = 1'b1;
      sent_q.delete();
      for (i = 0; i < 18; i++)
      begin
         next_byte(b);
         sent_q.push_back(b);
      end
      write_bytes(18);
      compare_val("tx_full", full_seen, 1'b1);
      for (i = 0; i < 17; i++)
         read_word(sent_q[i], 1'b0, 1'b0);   // 18th write was dropped
      repeat (WAIT_LIMIT) @(negedge clk);   // long enough for one more frame to land
      compare_val("rx_empty", rx_empty, 1'b1);
   endtask

   initial
   begin
      err_cnt     = 0;
      check_cnt   = 0;
      rng_state   = 32'd1448;
      full_seen   = 1'b0;
      reset       = 1'b1;
      dvsr        = 11'(DVSR);
      data_bits_7 = 1'b0;
      two_stop    = 1'b0;
      parity      = par_none;
      drv_rx      = 1'b1;
      loop_en     = 1'b0;
      wr_uart     = 1'b0;
      w_data      = 8'h00;
      rd_uart     = 1'b0;
      clr_overrun = 1'b0;
      repeat (8) @(negedge clk);
      reset = 1'b0;

      reset_values();
      loopback_8n1();
      loopback_formats();
      line_errors();
      rx_overrun();
      tx_fifo_full();

      $display("checks %0d, errors %0d", check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire
